//--- files.f
common/busPkg.sv
common/periphPkg.sv
uart/uartTx.sv
uart/uartRx.sv
source/pwmGen.sv
source/irqCtrl.sv
source/perSys.sv
tests/perSys_assertions.sv
tests/perSysTb.sv

//--- Bender.yml
package:
  name: persys

sources:
  - common/busPkg.sv
  - common/periphPkg.sv
  - uart/uartTx.sv
  - uart/uartRx.sv
  - source/pwmGen.sv
  - source/irqCtrl.sv
  - source/perSys.sv
  - target: test
    files:
      - tests/perSys_assertions.sv
      - tests/perSysTb.sv

//--- tests/perSysTb.sv
// Testbench for the I/O subsystem, with txd looped back to rxd
// Drives the bus 1 ns after the rising edge and checks UART, PWM, IRQ, timer and GPIO
`timescale 1ns/1ps

module perSysTb;

	logic clk = 1'b0;
	logic reset = 1'b1;
	busPkg::busReq_t req;
	busPkg::word_t rdata;
	logic stall, trap, txdLine, pwmOut, irq;
	logic [3:0] gpIn;
	busPkg::wordAddr_t ivector;

	busPkg::wordAddr_t dataAddr, statusAddr, pwmAddr, timerAddr, enAddr;
	busPkg::wordAddr_t vecVal [4];		// Vector registers as written
	longint unsigned cycleCount = 0;	// Local cycle count, timer reference
	int errorCount = 0;
	int checkCount = 0;

	// Pending compares, handed from stimulus to the compare process
	string chkName[$];
	busPkg::word_t chkGot[$];
	busPkg::word_t chkExp[$];
	time chkTime[$];

	perSys i_dut (
		.clk(clk), .reset(reset), .req(req), .rdata(rdata), .stall(stall),
		.trap(trap), .gpIn(gpIn), .rxd(txdLine), .txd(txdLine),	// Loopback
		.pwmOut(pwmOut), .irq(irq), .ivector(ivector)
	);

	always #5 clk = ~clk;	// 10 ns period
	always @(posedge clk) cycleCount <= cycleCount + 1;

	////////////////////
	// Reference model

	// Status word, bit 0 up: rxValid, txRdy, rxFrameErr, rxOverrun, pwmIrq
	function automatic busPkg::word_t expectedStatus(input logic rxV, input logic txR,
			input logic frameErr, input logic overrun, input logic pwmI);
		return {27'h0, pwmI, overrun, frameErr, txR, rxV};
	endfunction

	// Set at count zero, cleared on the duty match
	function automatic int pwmHighTime(input periphPkg::pwmCount_t duty);
		if (duty > periphPkg::pwmMax) begin
			return periphPkg::pwmMax + 1;	// Never matches
		end
		return duty;
	endfunction

	// Returns {irq, vector index}; trap, then RX, TX, PWM
	function automatic logic [2:0] expectedIrq(input logic trapIn, input periphPkg::irqEn_t en,
			input logic rxV, input logic txR, input logic pwmI);
		logic [2:0] pend;
		pend = en & {pwmI, txR, rxV};
		if (trapIn) return {1'b1, 2'd0};
		if (pend[0]) return {1'b1, 2'd1};
		if (pend[1]) return {1'b1, 2'd2};
		if (pend[2]) return {1'b1, 2'd3};
		return 3'b000;
	endfunction

	function automatic busPkg::wordAddr_t ioAddr(input busPkg::ioField_t off, input logic [2:0] low);
		return {busPkg::ioRegion, 21'h0, off, low};	// low is byte address bits 4..2
	endfunction

	////////////////////
	// Bus and wait tasks

	// One access; holds the request while stall is high
	task automatic busAccess(input busPkg::wordAddr_t a, input busPkg::word_t wd,
			input busPkg::strobe_t st, output busPkg::word_t rd, output int stallCycles);
		@(posedge clk);
		#1;
		req = '{addr: a, wdata: wd, wstrb: st};
		stallCycles = 0;
		@(negedge clk);
		while (stall && stallCycles < 30 * periphPkg::uartDivider) begin
			@(negedge clk);
			stallCycles++;
		end
		assert (!stall) else begin
			errorCount++;
			$display("Bus access to %h still stalled after %0d cycles", a, stallCycles);
		end
		rd = rdata;	// Combinational read, stable at the falling edge
		@(posedge clk);
		#1;
		req = '{default: '0};	// Outside the I/O area
	endtask

	task automatic busWrite(input busPkg::wordAddr_t a, input busPkg::word_t wd,
			input busPkg::strobe_t st);
		busPkg::word_t unused;
		int stalls;
		busAccess(a, wd, st, unused, stalls);
	endtask

	task automatic busRead(input busPkg::wordAddr_t a, output busPkg::word_t rd);
		int stalls;
		busAccess(a, '0, '0, rd, stalls);
	endtask

	// Polls status until a flag is set
	task automatic waitStatusBit(input int bitIdx);
		busPkg::word_t st;
		int polls;
		polls = 0;
		do begin
			busRead(statusAddr, st);
			polls++;
		end while (!st[bitIdx] && polls < 20 * periphPkg::uartDivider);
		assert (st[bitIdx]) else begin
			errorCount++;
			$display("Status bit %0d never came up", bitIdx);
		end
	endtask

	task automatic waitPwmLevel(input logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (pwmOut !== level && n < 2 * (periphPkg::pwmMax + 1)) begin
			@(negedge clk);
			n++;
		end
		assert (pwmOut === level) else begin
			errorCount++;
			$display("pwmOut did not reach %b within two periods", level);
		end
	endtask

	// Starts right after a rising edge of pwmOut, ends at the next one
	task automatic measurePulse(output int high, output int low);
		high = 0;
		low = 0;
		while (pwmOut === 1'b1 && high <= periphPkg::pwmMax) begin
			high++;
			@(negedge clk);
		end
		while (pwmOut === 1'b0 && low <= periphPkg::pwmMax) begin
			low++;
			@(negedge clk);
		end
	endtask

	task automatic expectValue(input string name, input busPkg::word_t got, input busPkg::word_t exp);
		chkName.push_back(name);
		chkGot.push_back(got);
		chkExp.push_back(exp);
		chkTime.push_back($time);
		checkCount++;
	endtask

	////////////////////
	// Compare process

	always @(posedge clk) begin : compare
		string name;
		busPkg::word_t got, exp;
		time t;
		while (chkName.size() > 0) begin
			name = chkName.pop_front();
			got = chkGot.pop_front();
			exp = chkExp.pop_front();
			t = chkTime.pop_front();
			assert (got === exp) else begin
				errorCount++;
				$display("FAILED at %0d ns: %s = %0h, expected %0h", t, name, got, exp);
			end
		end
	end

	// Twice 20 UART frames plus 20 PWM periods
	initial begin : watchdog
		#(2 * (20 * 10 * periphPkg::uartDivider + 20 * (periphPkg::pwmMax + 1)) * 10);
		$display("Watchdog expired, the tests did not finish in time");
		$display("TB FAILED");
		$finish;
	end

	////////////////////
	// Stimulus

	initial begin : stimulus
		busPkg::word_t rd, t0;
		periphPkg::uartByte_t b0, b1;
		periphPkg::pwmCount_t duty;
		longint unsigned c0;
		int stalls, high, low;
		logic rxV;
		logic [2:0] expIrq;
		void'($urandom(32'he07590c5));	// Seed once
		dataAddr = ioAddr(busPkg::offUart, 3'd0);
		statusAddr = ioAddr(busPkg::offUart, 3'd1);
		pwmAddr = ioAddr(busPkg::offPwm, 3'd0);
		timerAddr = ioAddr(busPkg::offTimer, 3'd0);
		enAddr = ioAddr(busPkg::offIrq, 3'd0);
		req = '{addr: statusAddr, wdata: '0, wstrb: '0};
		trap = 1'b0;
		gpIn = 4'h0;

		// Reset state, read while reset is held
		repeat (2) @(posedge clk);
		@(negedge clk);
		expectValue("rdata status", rdata, expectedStatus(1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		expectValue("irq", irq, 0);
		expectValue("txd", txdLine, 1);
		@(posedge clk);
		#1;
		reset = 1'b0;
		req = '{default: '0};

		// Loopback; PWM count starts at zero so pwmIrq sets on the first edge
		b0 = periphPkg::uartByte_t'($urandom);
		busWrite(dataAddr, b0, 4'h1);
		waitStatusBit(0);
		waitStatusBit(1);
		busRead(statusAddr, rd);
		expectValue("rdata status", rd, expectedStatus(1'b1, 1'b1, 1'b0, 1'b0, 1'b1));
		busRead(dataAddr, rd);
		expectValue("rdata rx byte", rd, b0);
		busRead(statusAddr, rd);
		expectValue("rdata status", rd, expectedStatus(1'b0, 1'b1, 1'b0, 1'b0, 1'b1));

		// Write into a busy transmitter, then a blocking read
		b0 = periphPkg::uartByte_t'($urandom);
		b1 = periphPkg::uartByte_t'($urandom);
		busWrite(dataAddr, b0, 4'h1);
		busAccess(dataAddr, b1, 4'h1, rd, stalls);
		expectValue("stall on tx write", stalls != 0, 1);
		busRead(dataAddr, rd);
		expectValue("rdata rx byte", rd, b0);
		busAccess(dataAddr, '0, '0, rd, stalls);	// Receiver empty here
		expectValue("stall on rx read", stalls != 0, 1);
		expectValue("rdata rx byte", rd, b1);

		// Two frames without a read
		b0 = periphPkg::uartByte_t'($urandom);
		b1 = periphPkg::uartByte_t'($urandom);
		busWrite(dataAddr, b0, 4'h1);
		busWrite(dataAddr, b1, 4'h1);
		waitStatusBit(3);
		waitStatusBit(1);
		busRead(statusAddr, rd);
		expectValue("rdata status", rd, expectedStatus(1'b1, 1'b1, 1'b0, 1'b1, 1'b1));
		busRead(dataAddr, rd);
		expectValue("rdata rx byte", rd, b1);	// Newest frame kept
		busRead(statusAddr, rd);
		expectValue("rdata status", rd, expectedStatus(1'b0, 1'b1, 1'b0, 1'b0, 1'b1));

		////////////////////
		// PWM

		duty = periphPkg::pwmCount_t'($urandom_range(periphPkg::pwmMax, 1));
		busWrite(pwmAddr, duty, 4'h1);
		for (int k = 0; k < 4; k++) begin
			waitPwmLevel(1'b0);
			waitPwmLevel(1'b1);	// First period with the new duty
			repeat (2) begin
				measurePulse(high, low);
				expectValue("pwmOut high cycles", high, pwmHighTime(duty));
				expectValue("pwmOut period", high + low, periphPkg::pwmMax + 1);
			end
			busRead(statusAddr, rd);	// Count is small here
			expectValue("rdata status", rd, expectedStatus(1'b0, 1'b1, 1'b0, 1'b0, 1'b1));
			duty = periphPkg::pwmCount_t'($urandom_range(periphPkg::pwmMax, 1));
			busWrite(pwmAddr, duty, 4'h1);
			busRead(statusAddr, rd);
			expectValue("rdata status", rd, expectedStatus(1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		end
		waitPwmLevel(1'b0);
		waitPwmLevel(1'b1);	// pwmIrq set again from here on

		////////////////////
		// Interrupts

		for (int i = 0; i < 4; i++) begin
			vecVal[i] = busPkg::wordAddr_t'($urandom);
			busWrite(ioAddr(busPkg::offIrq, {1'b1, 2'(i)}), {vecVal[i], 2'b00}, 4'hF);
		end
		for (int phase = 0; phase < 2; phase++) begin
			rxV = phase[0];
			if (rxV) begin
				busWrite(dataAddr, $urandom, 4'h1);	// Leave one byte waiting
				waitStatusBit(0);
				waitStatusBit(1);
			end
			for (int en = 0; en < 8; en++) begin
				busWrite(enAddr, en, 4'h1);
				busRead(enAddr, rd);
				expectValue("rdata irq enables", rd, en);
				for (int tr = 0; tr < 2; tr++) begin
					@(posedge clk);
					#1;
					trap = tr[0];
					@(negedge clk);
					expIrq = expectedIrq(tr[0], en[2:0], rxV, 1'b1, 1'b1);
					expectValue("irq", irq, expIrq[2]);
					if (expIrq[2]) begin
						expectValue("ivector", ivector, vecVal[expIrq[1:0]]);
					end
					@(posedge clk);
					#1;
					trap = 1'b0;
				end
			end
		end

		////////////////////
		// Timer and GPIO

		busRead(timerAddr, t0);
		c0 = cycleCount;
		repeat ($urandom_range(50, 5)) @(posedge clk);
		busRead(timerAddr, rd);
		expectValue("rdata timer difference", rd - t0, busPkg::word_t'(cycleCount - c0));
		repeat (3) begin
			@(posedge clk);
			#1;
			gpIn = 4'($urandom);
			busRead(pwmAddr, rd);
			expectValue("rdata gpIn", rd, {28'h0, gpIn});
		end

		repeat (2) @(posedge clk);	// Let the compare queue drain
		errorCount += i_dut.i_assertions.failCount;
		$display("Checks %0d, errors %0d, assertion failures %0d",
			checkCount, errorCount, i_dut.i_assertions.failCount);
		if (errorCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- tests/perSys_assertions.sv
// Concurrent checks bound into the I/O subsystem top level
// Idle UART line, stall scope and trap vector selection
`timescale 1ns/1ps

module perSys_assertions (
	input logic clk,
	input logic reset,
	input busPkg::busReq_t req,
	input logic stall,
	input logic txd,
	input logic txRdy,
	input logic trap,
	input logic irq,
	input busPkg::wordAddr_t ivector	// Handler address
);

	int failCount = 0;				// Failed assertions so far
	busPkg::wordAddr_t vec0;		// Vector register 0 as last written on the bus

	// Vector 0 write, byte address 0xF0 with all four lanes
	always_ff @(posedge clk) begin
		if (req.addr[29:27] == busPkg::ioRegion && req.addr[5:3] == busPkg::offIrq
				&& req.addr[2:0] == 3'b100 && (&req.wstrb)) begin
			vec0 <= req.wdata[31:2];
		end
	end

	// Idle transmitter holds the line high
	txdIdle: assert property (@(posedge clk) disable iff (reset) txRdy |-> txd)
		else begin
			$error("txd low while txRdy is high");
			failCount++;
		end

	// Only UART data accesses may stall
	stallScope: assert property (@(posedge clk) disable iff (reset)
			stall |-> (req.addr[29:27] == busPkg::ioRegion
				&& req.addr[5:3] == busPkg::offUart && !req.addr[0]))
		else begin
			$error("stall high outside a UART data access");
			failCount++;
		end

	trapVector: assert property (@(posedge clk) disable iff (reset)
			trap |-> (irq && ivector == vec0))
		else begin
			$error("trap did not select vector 0");
			failCount++;
		end

endmodule

bind perSys perSys_assertions i_assertions (
	.clk(clk), .reset(reset), .req(req), .stall(stall), .txd(txd), .txRdy(txRdy),
	.trap(trap), .irq(irq), .ivector(ivector)
);

//--- source/perSys.sv
// I/O subsystem top: region and register decode, read mux, timer and stall
// Connects the UART, PWM and interrupt blocks to the external bus master
`timescale 1ns/1ps

module perSys (
	input logic clk,
	input logic reset,
	input busPkg::busReq_t req,				// Held by the master while stalled
	output busPkg::word_t rdata,
	output logic stall,
	input logic trap,
	input logic [3:0] gpIn,
	input logic rxd,
	output logic txd,
	output logic pwmOut,
	output logic irq,
	output busPkg::wordAddr_t ivector
);

	busPkg::wordAddr_t addr;
	busPkg::ioField_t offset;			// Byte address bits 7..5
	logic ioSel;
	logic uartData, uartStat;
	logic rxRd, txWr;					// Raw strobes, before stall gating
	logic pwmWr, enWr, vecWr;
	logic rxValid, txRdy, rxOverrun, rxFrameErr;
	periphPkg::uartFlags_t uartFlags;
	periphPkg::uartByte_t rxData;
	periphPkg::irqEn_t irqEn;
	logic pwmIrq;
	busPkg::word_t timerCount;

	////////////////////
	// Decode

	assign addr = req.addr;
	assign ioSel = (addr[29:27] == busPkg::ioRegion);
	assign offset = addr[5:3];
	assign uartData = ioSel && offset == busPkg::offUart && !addr[0];	// Byte bit 2 clear
	assign uartStat = ioSel && offset == busPkg::offUart && addr[0];

	assign rxRd = uartData && (req.wstrb == '0);
	assign txWr = uartData && req.wstrb[0];

	// Hold the master on an empty receiver or a busy transmitter
	assign stall = (rxRd && !rxValid) || (txWr && !txRdy);

	assign pwmWr = ioSel && offset == busPkg::offPwm && req.wstrb[0] && !stall;
	assign enWr = ioSel && offset == busPkg::offIrq && !addr[2] && req.wstrb[0] && !stall;
	assign vecWr = ioSel && offset == busPkg::offIrq && addr[2] && (&req.wstrb) && !stall;

	assign uartFlags = '{
		rxValid: rxValid,
		txRdy: txRdy,
		rxOverrun: rxOverrun,
		rxFrameErr: rxFrameErr
	};

	////////////////////
	// Timer

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			timerCount <= '0;
		end else begin
			timerCount <= timerCount + 1'b1;
		end
	end

	////////////////////
	// Read mux

	always_comb begin
		rdata = '0;	// Outside I/O and unmapped offsets
		if (ioSel) begin
			case (offset)
				busPkg::offUart: begin
					if (uartStat) begin
						rdata = {27'h0, pwmIrq, rxOverrun, rxFrameErr, txRdy, rxValid};
					end else begin
						rdata = {24'h0, rxData};
					end
				end
				busPkg::offPwm: rdata = {28'h0, gpIn};
				busPkg::offTimer: rdata = timerCount;
				busPkg::offIrq: rdata = addr[2] ? '0 : {29'h0, irqEn};	// Vectors write only
				default: rdata = '0;
			endcase
		end
	end

	////////////////////
	// Peripherals

	uartTx i_uartTx (
		.clk(clk), .reset(reset),
		.wr(txWr && !stall), .data(req.wdata[7:0]),
		.txd(txd), .txRdy(txRdy)
	);

	uartRx i_uartRx (
		.clk(clk), .reset(reset),
		.rxd(rxd), .rd(rxRd && !stall), .data(rxData),
		.rxValid(rxValid), .rxOverrun(rxOverrun), .rxFrameErr(rxFrameErr)
	);

	pwmGen i_pwmGen (
		.clk(clk), .reset(reset),
		.wr(pwmWr), .duty(req.wdata[7:0]),
		.pwmOut(pwmOut), .pwmIrq(pwmIrq)
	);

	irqCtrl i_irqCtrl (
		.clk(clk), .reset(reset),
		.enWr(enWr), .vecWr(vecWr), .vecSel(addr[1:0]), .wdata(req.wdata),
		.flags(uartFlags), .pwmIrq(pwmIrq), .trap(trap),
		.irqEn(irqEn), .irq(irq), .ivector(ivector)
	);

endmodule

//--- source/irqCtrl.sv
// Interrupt controller: enable bits, four vector registers, priority encoder
// Priority is trap, then UART RX, UART TX, PWM
`timescale 1ns/1ps

module irqCtrl (
	input logic clk,
	input logic reset,
	input logic enWr,						// Enable register write
	input logic vecWr,						// Vector register write
	input periphPkg::vecSel_t vecSel,		// Which vector
	input busPkg::word_t wdata,
	input periphPkg::uartFlags_t flags,
	input logic pwmIrq,
	input logic trap,						// Core trap pulse
	output periphPkg::irqEn_t irqEn,
	output logic irq,
	output busPkg::wordAddr_t ivector		// Handler address
);

	busPkg::wordAddr_t vecTab [4];			// Vector registers
	periphPkg::irqEn_t pending;
	periphPkg::vecSel_t vecIdx;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			irqEn <= '0;
		end else if (enWr) begin
			irqEn <= wdata[2:0];
		end
	end

	// Word aligned, byte bits 1..0 dropped
	always_ff @(posedge clk) begin
		if (vecWr) begin
			vecTab[vecSel] <= wdata[31:2];
		end
	end

	////////////////////
	// Pending and priority

	assign pending = {
		irqEn[2] & pwmIrq,			// PWM period
		irqEn[1] & flags.txRdy,		// TX ready for more
		irqEn[0] & flags.rxValid	// RX byte waiting
	};

	always_comb begin
		if (trap) begin
			vecIdx = 2'd0;			// ECALL / EBREAK first
		end else if (pending[0]) begin
			vecIdx = 2'd1;
		end else if (pending[1]) begin
			vecIdx = 2'd2;
		end else begin
			vecIdx = 2'd3;			// PWM, or don't care when irq is low
		end
	end

	assign ivector = vecTab[vecIdx];
	assign irq = (|pending) | trap;

endmodule

//--- source/pwmGen.sv
// 181-step PWM generator with a period interrupt
// New duty takes effect at the next period; a duty write clears the interrupt
`timescale 1ns/1ps

module pwmGen (
	input logic clk,
	input logic reset,
	input logic wr,							// Duty write
	input periphPkg::pwmCount_t duty,		// High cycles per period
	output logic pwmOut,
	output logic pwmIrq						// Set each period start
);

	periphPkg::pwmCount_t count;		// 0..pwmMax
	periphPkg::pwmCount_t dutyReg;		// As written
	periphPkg::pwmCount_t dutyBuf;		// Copy in use this period
	logic termCount;
	logic zeroCount;

	assign termCount = (count == periphPkg::pwmMax);
	assign zeroCount = (count == '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
			dutyReg <= '0;
			dutyBuf <= '0;
		end else begin
			count <= termCount ? '0 : count + 1'b1;
			if (wr) begin
				dutyReg <= duty;
			end
			if (termCount) begin
				dutyBuf <= dutyReg;	// Reload only between periods
			end
		end
	end

	////////////////////
	// Output and IRQ

	// Match wins over zero count, so a duty of 0 keeps the output low
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pwmOut <= 1'b0;
			pwmIrq <= 1'b0;
		end else begin
			if (count == dutyBuf) begin
				pwmOut <= 1'b0;
			end else if (zeroCount) begin
				pwmOut <= 1'b1;
			end
			if (zeroCount) begin
				pwmIrq <= 1'b1;
			end else if (wr) begin
				pwmIrq <= 1'b0;	// Duty write acknowledges
			end
		end
	end

endmodule

//--- uart/uartRx.sv
// 8N1 UART receiver
// Samples mid-bit after a two-stage synchronizer; rd clears valid and overrun
`timescale 1ns/1ps

module uartRx (
	input logic clk,
	input logic reset,
	input logic rxd,						// Serial in, asynchronous
	input logic rd,							// Data read, clears flags
	output periphPkg::uartByte_t data,		// Last received byte
	output logic rxValid,
	output logic rxOverrun,
	output logic rxFrameErr
);

	logic [1:0] rxSync;						// Synchronizer, [1] is safe to use
	logic rxBit;
	logic rxEdge;
	periphPkg::divCount_t baudCnt;
	logic midTick;							// Middle of a bit
	periphPkg::rxState_t state;
	logic [3:0] bitCnt;						// Samples taken in rxShift
	logic [8:0] shiftReg;					// Stop bit ends up in [8]
	logic stopBit;							// Stop bit of the latched frame
	logic [1:0] validHist;					// 01 data, 11 overrun

	assign rxBit = rxSync[1];
	assign rxEdge = rxSync[1] ^ rxSync[0];
	assign midTick = (baudCnt == periphPkg::baudMid);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxSync <= 2'b11;	// Idle line
		end else begin
			rxSync <= {rxSync[0], rxd};
		end
	end

	// Realigned on every line edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			baudCnt <= '0;
		end else if (rxEdge || baudCnt == periphPkg::baudLast) begin
			baudCnt <= '0;
		end else begin
			baudCnt <= baudCnt + 1'b1;
		end
	end

	////////////////////
	// Frame FSM

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= periphPkg::rxIdle;
			bitCnt <= '0;
		end else begin
			case (state)
				periphPkg::rxIdle: if (midTick && !rxBit) begin
					state <= periphPkg::rxShift;	// Start bit still low at mid-bit
					bitCnt <= '0;
				end
				periphPkg::rxShift: if (midTick) begin
					bitCnt <= bitCnt + 1'b1;
					if (bitCnt == 4'd8) begin		// 8 data + stop
						state <= periphPkg::rxDone;
					end
				end
				default: state <= periphPkg::rxIdle;
			endcase
		end
	end

	// LSB first, so the first data bit lands in [0]
	always_ff @(posedge clk) begin
		if (state == periphPkg::rxShift && midTick) begin
			shiftReg <= {rxBit, shiftReg[8:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (state == periphPkg::rxDone) begin
			data <= shiftReg[7:0];
		end
	end

	// Reset high so no framing error shows before the first frame
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			stopBit <= 1'b1;
		end else if (state == periphPkg::rxDone) begin
			stopBit <= shiftReg[8];
		end
	end

	// Second frame without a read shifts the one up into overrun
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			validHist <= '0;
		end else if (state == periphPkg::rxDone) begin
			validHist <= {validHist[0], 1'b1};
		end else if (rd) begin
			validHist <= '0;
		end
	end

	assign rxValid = validHist[0];
	assign rxOverrun = validHist[1];
	assign rxFrameErr = ~stopBit;

endmodule

//--- uart/uartTx.sv
// 8N1 UART transmitter
// A write strobe loads the byte and starts the frame, txRdy flags idle
`timescale 1ns/1ps

module uartTx (
	input logic clk,
	input logic reset,
	input logic wr,							// Start transmission
	input periphPkg::uartByte_t data,		// Byte to send
	output logic txd,						// Serial out, idle high
	output logic txRdy						// Ready for a new byte
);

	periphPkg::divCount_t baudCnt;	// Cycles within the current bit
	logic baudTick;					// Last cycle of a bit
	logic [8:0] shiftReg;			// Start bit plus data, LSB goes out
	logic [3:0] bitCnt;				// Bits left, zero when idle
	logic busy;

	assign baudTick = (baudCnt == periphPkg::baudLast);
	assign busy = |bitCnt;

	////////////////////
	// Baud counter

	// Restarts on every write so the start bit gets a full bit time
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			baudCnt <= '0;
		end else if (wr || baudTick) begin
			baudCnt <= '0;
		end else begin
			baudCnt <= baudCnt + 1'b1;
		end
	end

	////////////////////
	// Shifter

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			shiftReg <= 9'h1FF;							// Line idle
		end else if (wr) begin
			shiftReg <= {data, 1'b0};					// Data plus start bit
		end else if (baudTick) begin
			shiftReg <= {1'b1, shiftReg[8:1]};		// Ones fill in, last one is the stop bit
		end
	end

	// Counts down one per bit time
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			bitCnt <= '0;
		end else if (wr) begin
			bitCnt <= periphPkg::frameBits;
		end else if (busy && baudTick) begin
			bitCnt <= bitCnt - 1'b1;
		end
	end

	assign txd = shiftReg[0];
	assign txRdy = ~busy;

endmodule

//--- common/periphPkg.sv
// Peripheral constants and types: UART timing, PWM period, interrupt fields
// Referenced by the UART, PWM and interrupt blocks and by the top level
package periphPkg;

	////////////////////
	// UART

	localparam int unsigned clkHz = 4_000_000;	// System clock
	localparam int unsigned baudRate = 115_200;

	// Clock cycles per bit, rounded to nearest
	localparam int unsigned uartDivider = (clkHz + baudRate / 2) / baudRate;

	typedef logic [5:0] divCount_t;	// Baud counter
	typedef logic [7:0] uartByte_t;	// Data byte

	localparam divCount_t baudLast = divCount_t'(uartDivider - 1);	// Wrap value
	localparam divCount_t baudMid = divCount_t'(uartDivider / 2 - 1);	// Mid-bit sample

	// Start, 8 data, stop
	localparam logic [3:0] frameBits = 4'd10;

	// Receiver and transmitter flags, as seen by the interrupt logic
	typedef struct packed {
		logic rxValid;		// Byte waiting
		logic txRdy;		// Transmitter idle
		logic rxOverrun;	// Byte lost before read
		logic rxFrameErr;	// Stop bit sampled low
	} uartFlags_t;

	// Receiver FSM
	typedef enum logic [1:0] {
		rxIdle,		// Waiting for a low start bit at mid-bit
		rxShift,	// Sampling data and stop bits
		rxDone		// Frame complete, latch it
	} rxState_t;

	////////////////////
	// PWM

	typedef logic [7:0] pwmCount_t;
	localparam pwmCount_t pwmMax = 8'd180;	// Terminal count, 181 steps

	////////////////////
	// Interrupts

	typedef logic [2:0] irqEn_t;	// Bit 0 RX, bit 1 TX, bit 2 PWM
	typedef logic [1:0] vecSel_t;	// Vector register index

endpackage

//--- common/busPkg.sv
// Bus word types, request struct and I/O address map
// Shared by the top-level decoder and the bus tasks of the testbench
package busPkg;

	////////////////////
	// Bus words

	typedef logic [31:0] word_t;		// Data word
	typedef logic [29:0] wordAddr_t;	// Byte address bits 31..2
	typedef logic [3:0] strobe_t;		// One strobe per byte lane
	typedef logic [2:0] ioField_t;		// Region and offset fields

	// Master request, driven every cycle
	// No valid bit, a cycle with all strobes low is a read
	typedef struct packed {
		wordAddr_t addr;	// Word address
		word_t wdata;		// Write data, byte lanes as on the bus
		strobe_t wstrb;		// Write strobes
	} busReq_t;

	////////////////////
	// I/O address map

	// Top three address bits select the I/O area (0xE0000000 up)
	localparam ioField_t ioRegion = 3'b111;

	// Offset field is byte address bits 7..5
	localparam ioField_t offUart = 3'd0;	// 0x00 data, 0x04 status
	localparam ioField_t offPwm = 3'd1;		// 0x20 duty write, GPIO read
	localparam ioField_t offTimer = 3'd3;	// 0x60 free-running count
	localparam ioField_t offIrq = 3'd7;		// 0xE0 enables, 0xF0 vectors

endpackage
